// File: filelist.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_bus_pkg.sv
verilog/rv_decode.sv
verilog/rv_fetch.sv
verilog/rv_issue_queue.sv
verilog/rv_decode_top.sv
tb/wb_imem_model.sv
tb/tb_rv_decode_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_rv_decode_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  exit 1
fi
exit 0

// File: tb/tb_rv_decode_top.sv
`include "rv_decode_cfg.svh"

module tb_rv_decode_top;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  logic     clk_in;
  logic     rst;
  logic     redirect_valid;
  addr_t    redirect_pc;
  logic     out_ready;
  wb_req_t  imem_req;
  wb_rsp_t  imem_rsp;
  decoded_t out;
  logic     out_valid;
  word_t    prog[$];

  rv_decode_top DUT (
    .clk_in         (clk_in),
    .rst            (rst),
    .imem_req       (imem_req),
    .imem_rsp       (imem_rsp),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .out            (out),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
  );

  wb_imem_model imem (
    .clk_in (clk_in),
    .rst    (rst),
    .req    (imem_req),
    .rsp    (imem_rsp)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  function automatic word_t r_fmt(logic [6:0] f7, logic [2:0] f3);
    return {f7, 5'd3, 5'd2, f3, 5'd1, 7'b0110011};
  endfunction

  function automatic word_t i_fmt(int imm, logic [2:0] f3, logic [6:0] op);
    logic [31:0] v;
    v = imm;
    return {v[11:0], 5'd2, f3, 5'd5, op};
  endfunction

  function automatic word_t s_fmt(int imm);
    logic [31:0] v;
    v = imm;
    return {v[11:5], 5'd6, 5'd7, 3'b010, v[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_fmt(int imm, logic [2:0] f3);
    logic [31:0] v;
    v = imm;
    return {v[12], v[10:5], 5'd9, 5'd8, f3, v[4:1], v[11], 7'b1100011};
  endfunction

  function automatic word_t j_fmt(int imm);
    logic [31:0] v;
    v = imm;
    return {v[20], v[10:1], v[11], v[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic alu_func_e ref_alu(logic [2:0] f3, logic alt);
    case (f3)
      3'd0:    return alt ? SUB : ADD;
      3'd1:    return SLL;
      3'd2:    return SLT;
      3'd3:    return SLTU;
      3'd4:    return XOR;
      3'd5:    return alt ? SRA : SRL;
      3'd6:    return OR;
      default: return AND;
    endcase
  endfunction

  // RV32I base encoding rules
  function automatic decoded_t ref_decode(word_t w, addr_t pc);
    decoded_t   d;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    d          = '0;
    d.pc       = pc;
    d.itype    = OP;
    d.alu_func = ADD;
    d.br_func  = NONE;
    f3         = w[14:12];
    f7         = w[31:25];
    imm_i      = {{20{w[31]}}, w[31:20]};
    case (w[6:0])
      7'b0110011: begin
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        d.rd       = w[11:7];
        d.alu_func = ref_alu(f3, f7 == 7'h20);
        d.illegal  = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      7'b0010011: begin
        d.itype    = OPIMM;
        d.rs1      = w[19:15];
        d.rd       = w[11:7];
        d.imm      = imm_i;
        d.alu_func = ref_alu(f3, f3 == 3'd5 && f7 == 7'h20);  // Shifts only
        d.illegal  = (f3 == 3'd1 && f7 != 7'h00) ||
                     (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      end
      7'b1100011: begin
        d.itype = BRANCH;
        d.rs1   = w[19:15];
        d.rs2   = w[24:20];
        d.imm   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        case (f3)
          3'd0:    d.br_func = EQ;
          3'd1:    d.br_func = NE;
          3'd4:    d.br_func = LT;
          3'd5:    d.br_func = GE;
          3'd6:    d.br_func = LTU;
          3'd7:    d.br_func = GEU;
          default: d.illegal = 1'b1;
        endcase
      end
      7'b0110111, 7'b0010111: begin
        d.itype = (w[5]) ? LUI : AUIPC;
        d.rd    = w[11:7];
        d.imm   = {w[31:12], 12'b0};
      end
      7'b1101111: begin
        d.itype = JAL;
        d.rd    = w[11:7];
        d.imm   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111, 7'b0000011, 7'b1110011: begin
        d.itype = (w[6:0] == 7'b1100111) ? JALR : (w[6:0] == 7'b0000011) ? LOAD : SYSTEM;
        d.rs1   = w[19:15];
        d.rd    = w[11:7];
        d.imm   = imm_i;
      end
      7'b0100011: begin
        d.itype = STORE;
        d.rs1   = w[19:15];
        d.rs2   = w[24:20];
        d.imm   = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      default: d.illegal = 1'b1;
    endcase
    if (d.illegal) begin
      d.itype    = OP;
      d.alu_func = ADD;
    end
    return d;
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(string name, logic [127:0] exp, logic [127:0] act);
    if (exp !== act) begin
      fail_now($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic load_prog(addr_t base);
    foreach (prog[i]) begin
      imem.mem[base[9:2] + i] = prog[i];
    end
  endtask

  // Program goes in at the reset PC while reset is held for 4 cycles
  task automatic reset_with_prog(int delay);
    @(posedge clk_in);
    rst <= 1'b1;
    @(negedge clk_in);
    imem.ack_delay = delay;
    load_prog(`RV_RESET_PC);
    repeat (4) @(posedge clk_in);
    rst <= 1'b0;
  endtask

  // Takes n transfers from out and compares them with prog decoded from base
  task automatic collect(string name, addr_t base, int n, bit stall);
    int       got;
    int       waited;
    logic     stalled;
    decoded_t held;
    got     = 0;
    waited  = 0;
    stalled = 1'b0;
    while (got < n) begin
      @(posedge clk_in);
      out_ready <= stall ? 1'($urandom_range(0, 1)) : 1'b1;
      @(negedge clk_in);
      if (imem_req.cyc || imem_req.stb) begin
        check({name, " wishbone"}, {1'b1, 1'b1, 1'b0, 4'hf},
              {imem_req.cyc, imem_req.stb, imem_req.we, imem_req.sel});
      end
      if (stalled) begin
        check({name, " stall hold"}, held, out);
      end
      stalled = out_valid && !out_ready;
      held    = out;
      if (out_valid && out_ready) begin
        check(name, ref_decode(prog[got], base + addr_t'(4 * got)), out);
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > 200) begin
          fail_now($sformatf("Timeout in %s: no output transfer came for 200 cycles", name));
        end
      end
    end
  endtask

  task automatic run_prog(string name, int delay, bit stall);
    reset_with_prog(delay);
    collect(name, `RV_RESET_PC, prog.size(), stall);
  endtask

  task automatic set_alu_prog();
    prog = {r_fmt(7'h00, 3'd0), r_fmt(7'h20, 3'd0), r_fmt(7'h00, 3'd1), r_fmt(7'h00, 3'd2),
            r_fmt(7'h00, 3'd3), r_fmt(7'h00, 3'd4), r_fmt(7'h00, 3'd5), r_fmt(7'h20, 3'd5),
            r_fmt(7'h00, 3'd6), r_fmt(7'h00, 3'd7)};
  endtask

  task automatic set_imm_prog();
    prog = {i_fmt(-4, 3'd2, 7'b0000011), i_fmt(2047, 3'd2, 7'b0000011),
            s_fmt(-8), s_fmt(2044), b_fmt(-16, 3'd0), b_fmt(4094, 3'd1),
            i_fmt(-1, 3'd0, 7'b1100111), {20'hfffff, 5'd5, 7'b0110111},
            {20'h12345, 5'd6, 7'b0010111}, j_fmt(-2048), j_fmt(1048574)};
  endtask

  task automatic test_alu();
    set_alu_prog();
    run_prog("alu", 0, 1'b0);
  endtask

  task automatic test_imm();
    set_imm_prog();
    run_prog("imm", 1, 1'b0);
  endtask

  task automatic test_branch_illegal();
    prog = {b_fmt(8, 3'd0), b_fmt(8, 3'd1), b_fmt(8, 3'd4), b_fmt(8, 3'd5),
            b_fmt(8, 3'd6), b_fmt(8, 3'd7), i_fmt(5, 3'd1, 7'b0010011),
            i_fmt(3, 3'd5, 7'b0010011), i_fmt(32'h403, 3'd5, 7'b0010011),
            i_fmt(1024, 3'd0, 7'b0010011), 32'h0000_007f, b_fmt(8, 3'd2),
            i_fmt(32'h405, 3'd1, 7'b0010011), r_fmt(7'h20, 3'd1)};
    run_prog("branch_illegal", 0, 1'b0);
  endtask

  task automatic test_backpressure();
    set_alu_prog();
    run_prog("backpressure", 2, 1'b1);
  endtask

  task automatic test_ack_delay();
    set_imm_prog();
    for (int d = 0; d <= 5; d++) begin
      run_prog($sformatf("ack_delay_%0d", d), d, 1'b0);
    end
  endtask

  task automatic test_redirect();
    set_alu_prog();
    reset_with_prog(1);
    collect("redirect_pre", `RV_RESET_PC, 3, 1'b0);
    set_imm_prog();
    load_prog(32'h100);
    @(posedge clk_in);
    redirect_valid <= 1'b1;
    redirect_pc    <= 32'h102;  // Unaligned on purpose
    out_ready      <= 1'b0;
    @(posedge clk_in);
    redirect_valid <= 1'b0;
    collect("redirect_after", 32'h100, prog.size(), 1'b0);
  endtask

  initial begin
    rst            = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    out_ready      = 1'b0;
    void'($urandom(32'ha535_b342));
    test_alu();
    test_imm();
    test_branch_illegal();
    test_backpressure();
    test_ack_delay();
    test_redirect();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: tb/wb_imem_model.sv
module wb_imem_model (
  input  logic                clk_in,
  input  logic                rst,
  input  rv_bus_pkg::wb_req_t req,
  output rv_bus_pkg::wb_rsp_t rsp
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;

  word_t mem [0:255];
  int    ack_delay;  // Wait states before each ack
  int    wait_cnt;

  // Unloaded words read as addi x1, x0, word index
  initial begin
    ack_delay = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {12'(i), 5'd0, 3'b000, 5'd1, 7'b0010011};
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      rsp      <= '0;
      wait_cnt <= 0;
    end else if (req.cyc && req.stb && !rsp.ack) begin
      if (wait_cnt >= ack_delay) begin
        rsp.ack  <= 1'b1;
        rsp.dat  <= mem[req.adr[9:2]];
        wait_cnt <= 0;
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end else begin
      rsp.ack <= 1'b0;  // Single-cycle ack
    end
  end

endmodule

// File: verilog/rv_bus_pkg.sv
package rv_bus_pkg;
  `include "rv_decode_cfg.svh"

  // Wishbone classic master side
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    rv_isa_pkg::addr_t adr;
    logic [3:0]        sel;
    rv_isa_pkg::word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    rv_isa_pkg::word_t dat;
  } wb_rsp_t;

  typedef struct packed {
    rv_isa_pkg::addr_t                   pc;     // PC of lane 0
    rv_isa_pkg::word_t [`RV_LANES-1:0]   words;
  } fetch_bundle_t;

endpackage

// File: verilog/rv_decode.sv
module rv_decode #(
  parameter int LANE = 0
) (
  input  rv_isa_pkg::word_t    instr,
  input  rv_isa_pkg::addr_t    base_pc,
  output rv_isa_pkg::decoded_t dec
);
  import rv_isa_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  alu_func_e  alu_f;
  br_func_e   br_f;
  logic       shift;
  logic       f7_used;
  logic       alt;
  logic       alu_ok;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // Shared by OP and OPIMM
  always_comb begin
    shift   = (funct3 == 3'b001) || (funct3 == 3'b101);
    f7_used = (opcode == OPC_OP) || shift;  // ADDI and friends carry imm there
    alt     = f7_used && (funct7 == 7'h20);
    alu_ok  = !f7_used || (funct7 == 7'h00) ||
              (alt && (funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OPC_OP)));
    case (funct3)
      3'b000:  alu_f = alt ? SUB : ADD;
      3'b001:  alu_f = SLL;
      3'b010:  alu_f = SLT;
      3'b011:  alu_f = SLTU;
      3'b100:  alu_f = XOR;
      3'b101:  alu_f = alt ? SRA : SRL;
      3'b110:  alu_f = OR;
      default: alu_f = AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  br_f = EQ;
      3'b001:  br_f = NE;
      3'b100:  br_f = LT;
      3'b101:  br_f = GE;
      3'b110:  br_f = LTU;
      3'b111:  br_f = GEU;
      default: br_f = NONE;
    endcase
  end

  always_comb begin
    dec          = '0;
    dec.pc       = base_pc + addr_t'(4 * LANE);
    dec.itype    = OP;
    dec.alu_func = ADD;
    dec.br_func  = NONE;
    case (opcode)
      OPC_OP: begin
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        dec.alu_func = alu_f;
        dec.illegal  = !alu_ok;
      end
      OPC_OPIMM: begin
        dec.itype    = OPIMM;
        dec.rs1      = instr[19:15];
        dec.rd       = instr[11:7];
        dec.imm      = imm_i;
        dec.alu_func = alu_f;
        dec.illegal  = !alu_ok;
      end
      OPC_BRANCH: begin
        dec.itype   = BRANCH;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.imm     = imm_b;
        dec.br_func = br_f;
        dec.illegal = (br_f == NONE);
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.itype = (opcode == OPC_LUI) ? LUI : AUIPC;
        dec.rd    = instr[11:7];
        dec.imm   = imm_u;
      end
      OPC_JAL: begin
        dec.itype = JAL;
        dec.rd    = instr[11:7];
        dec.imm   = imm_j;
      end
      OPC_JALR, OPC_LOAD, OPC_SYSTEM: begin
        dec.itype = (opcode == OPC_JALR) ? JALR : (opcode == OPC_LOAD) ? LOAD : SYSTEM;
        dec.rs1   = instr[19:15];
        dec.rd    = instr[11:7];
        dec.imm   = imm_i;
      end
      OPC_STORE: begin
        dec.itype = STORE;
        dec.rs1   = instr[19:15];
        dec.rs2   = instr[24:20];
        dec.imm   = imm_s;
      end
      default: dec.illegal = 1'b1;
    endcase
    if (dec.illegal) begin
      dec.itype    = OP;
      dec.alu_func = ADD;
    end
  end

endmodule

// File: verilog/rv_decode_cfg.svh
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// Decode lanes and words per bundle, a power of two from 1 to 4
`define RV_LANES 2

`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: verilog/rv_decode_top.sv
`include "rv_decode_cfg.svh"

module rv_decode_top (
  input  logic                 clk_in,
  input  logic                 rst,
  output rv_bus_pkg::wb_req_t  imem_req,
  input  rv_bus_pkg::wb_rsp_t  imem_rsp,
  input  logic                 redirect_valid,
  input  rv_isa_pkg::addr_t    redirect_pc,
  output rv_isa_pkg::decoded_t out,
  output logic                 out_valid,
  input  logic                 out_ready
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  fetch_bundle_t            bundle;
  logic                     bundle_valid;
  logic                     bundle_ready;
  decoded_t [`RV_LANES-1:0] lanes;

  rv_fetch u_fetch (
    .clk_in         (clk_in),
    .rst            (rst),
    .imem_req       (imem_req),
    .imem_rsp       (imem_rsp),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .bundle         (bundle),
    .bundle_valid   (bundle_valid),
    .bundle_ready   (bundle_ready)
  );

  for (genvar g = 0; g < `RV_LANES; g++) begin : g_lane
    rv_decode #(.LANE(g)) u_decode (
      .instr   (bundle.words[g]),
      .base_pc (bundle.pc),
      .dec     (lanes[g])
    );
  end

  rv_issue_queue u_queue (
    .clk_in       (clk_in),
    .rst          (rst),
    .flush        (redirect_valid),
    .lanes_in     (lanes),
    .bundle_valid (bundle_valid),
    .bundle_ready (bundle_ready),
    .out          (out),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

endmodule

// File: verilog/rv_fetch.sv
`include "rv_decode_cfg.svh"

module rv_fetch (
  input  logic                      clk_in,
  input  logic                      rst,
  output rv_bus_pkg::wb_req_t       imem_req,
  input  rv_bus_pkg::wb_rsp_t       imem_rsp,
  input  logic                      redirect_valid,
  input  rv_isa_pkg::addr_t         redirect_pc,
  output rv_bus_pkg::fetch_bundle_t bundle,
  output logic                      bundle_valid,
  input  logic                      bundle_ready
);
  import rv_isa_pkg::*;

  localparam int CNT_W = (`RV_LANES > 1) ? $clog2(`RV_LANES) : 1;

  typedef enum logic [1:0] {IDLE, REQ, DRAIN, FULL} state_e;

  state_e           state;
  addr_t            fetch_pc;  // Word on the bus
  addr_t            pend_pc;   // Last redirect target
  addr_t            target;
  logic [CNT_W-1:0] word_cnt;
  logic             ack;
  logic             busy;
  logic             start;

  assign ack    = imem_rsp.ack;
  assign target = {redirect_pc[`RV_XLEN-1:2], 2'b00};
  assign busy   = (state == REQ) || (state == DRAIN);
  assign start  = !redirect_valid &&
                  ((state == IDLE) || (state == FULL && bundle_valid && bundle_ready));

  always_comb begin
    imem_req     = '0;
    imem_req.cyc = busy;
    imem_req.stb = busy;
    imem_req.adr = fetch_pc;
    imem_req.sel = 4'hf;  // Reads only
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state    <= IDLE;
      fetch_pc <= `RV_RESET_PC;
      word_cnt <= '0;
    end else begin
      if (state != REQ) begin
        word_cnt <= '0;
      end
      case (state)
        IDLE: begin
          if (start) begin
            state <= REQ;
          end else begin
            fetch_pc <= target;
          end
        end
        REQ: begin
          if (redirect_valid) begin
            state <= ack ? IDLE : DRAIN;  // Open read still owes an ack
            if (ack) begin
              fetch_pc <= target;
            end
          end else if (ack) begin
            fetch_pc <= fetch_pc + addr_t'(4);
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == CNT_W'(`RV_LANES - 1)) begin
              state <= FULL;
            end
          end
        end
        DRAIN: begin
          if (ack) begin
            state    <= IDLE;  // Data dropped
            fetch_pc <= redirect_valid ? target : pend_pc;
          end
        end
        FULL: begin
          if (redirect_valid) begin
            state    <= IDLE;
            fetch_pc <= target;
          end else if (start) begin
            state <= REQ;  // Prefetch behind the queue
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (redirect_valid) begin
      pend_pc <= target;
    end
    if (start) begin
      bundle.pc <= fetch_pc;
    end
    if (state == REQ && ack) begin
      bundle.words[word_cnt] <= imem_rsp.dat;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      bundle_valid <= 1'b0;
    end else if (redirect_valid || (bundle_valid && bundle_ready)) begin
      bundle_valid <= 1'b0;
    end else if (state == FULL) begin
      bundle_valid <= 1'b1;  // One cycle after the last word lands
    end
  end

  a_adr_stable: assert property (@(posedge clk_in) disable iff (rst)
    imem_req.stb && !ack |=> imem_req.stb && $stable(imem_req.adr));

endmodule

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;
  `include "rv_decode_cfg.svh"

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_XLEN-1:0] addr_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [6:0]          opcode_t;

  // RV32I major opcodes
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    OP, OPIMM, BRANCH, LUI, JAL, JALR, LOAD, STORE, AUIPC, SYSTEM
  } itype_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
  } alu_func_e;

  typedef enum logic [2:0] {
    EQ, NE, LT, GE, LTU, GEU, NONE
  } br_func_e;

  typedef struct packed {
    itype_e    itype;
    alu_func_e alu_func;
    br_func_e  br_func;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;      // Sign-extended
    addr_t     pc;
    logic      illegal;
  } decoded_t;

endpackage

// File: verilog/rv_issue_queue.sv
`include "rv_decode_cfg.svh"

module rv_issue_queue (
  input  logic                                  clk_in,
  input  logic                                  rst,
  input  logic                                  flush,
  input  rv_isa_pkg::decoded_t [`RV_LANES-1:0]  lanes_in,
  input  logic                                  bundle_valid,
  output logic                                  bundle_ready,
  output rv_isa_pkg::decoded_t                  out,
  output logic                                  out_valid,
  input  logic                                  out_ready
);
  import rv_isa_pkg::*;

  localparam int IDX_W = (`RV_LANES > 1) ? $clog2(`RV_LANES) : 1;

  decoded_t [`RV_LANES-1:0] entries;
  logic [IDX_W-1:0]         rd_idx;
  logic                     holding;  // Entries left to send
  logic                     fire;
  logic                     last_xfer;
  logic                     capture;

  assign fire         = out_valid && out_ready;
  assign last_xfer    = fire && (rd_idx == IDX_W'(`RV_LANES - 1));
  assign bundle_ready = !holding || last_xfer;
  assign capture      = bundle_valid && bundle_ready;
  assign out_valid    = holding;
  assign out          = entries[rd_idx];

  always_ff @(posedge clk_in) begin
    if (rst || flush) begin
      holding <= 1'b0;
      rd_idx  <= '0;
    end else if (capture) begin
      holding <= 1'b1;
      rd_idx  <= '0;
    end else if (fire) begin
      rd_idx <= rd_idx + 1'b1;
      if (last_xfer) begin
        holding <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (capture) begin
      entries <= lanes_in;
    end
  end

  // Bundle source keeps valid up until the handoff
  a_bundle_hold: assert property (@(posedge clk_in) disable iff (rst)
    bundle_valid && !bundle_ready && !flush |=> bundle_valid);

endmodule
